// File: rx_iq_pkg.sv
// rx iq shared definitions

package rx_iq_pkg;

    // one I or Q component
    localparam int iq_width = 16;

    // fill count width for the default depth of 32
    localparam int level_width = 6;

    // pacing period is count_top + 1 clocks
    localparam int count_top_default = 7;

    // fill thresholds that bend the pacing period
    localparam int low_mark_default  = 11;
    localparam int high_mark_default = 22;

    // i sits in the low half
    typedef struct packed {
        logic [iq_width-1:0] q;
        logic [iq_width-1:0] i;
    } iq_sample_t;

    // radio on 0, every other code takes the stream
    typedef enum logic [2:0] {
        src_radio  = 3'd0,
        src_stream = 3'd5
    } src_sel_e;

endpackage

// File: iq_fifo_if.sv
// iq fifo bus

interface iq_fifo_if #(
    parameter int DEPTH = 2 ** (rx_iq_pkg::level_width - 1)
);
    import rx_iq_pkg::*;

    // write side
    logic                       wr_en;
    iq_sample_t                 wr_data;
    logic                       full;

    // read side, head of queue always on rd_data
    logic                       rd_en;
    iq_sample_t                 rd_data;
    logic                       empty;

    logic [$clog2(DEPTH):0]     level;

    modport src  (output wr_en, output wr_data, input full);
    modport fifo (input wr_en, input wr_data, input rd_en,
                  output full, output rd_data, output empty, output level);
    modport ctrl (output rd_en, input empty, input level);

endinterface

// File: iq_source_mux.sv
// iq source select

module iq_source_mux (
    input  logic                          clk,
    input  logic                          rstn,
    input  rx_iq_pkg::src_sel_e           src_sel,
    input  logic [rx_iq_pkg::iq_width-1:0] radio_i,
    input  logic [rx_iq_pkg::iq_width-1:0] radio_q,
    input  logic                          radio_valid,
    input  rx_iq_pkg::iq_sample_t         s_data,
    input  logic                          s_valid,
    input  logic                          stream_en,
    input  logic                          fifo_in_en,
    input  logic                          pace,
    output logic                          s_ready,
    output logic                          overflow,
    iq_fifo_if.src                        wr
);
    import rx_iq_pkg::*;

    logic radio_sel;
    logic strobe;

    assign radio_sel = (src_sel == src_radio);

    // stream is only asked for on a pacing slot with room left
    assign s_ready = stream_en & pace & ~wr.full & ~radio_sel;

    always_comb begin
        if (radio_sel) begin
            wr.wr_data = '{q: radio_q, i: radio_i};
            strobe     = radio_valid & ~wr.full;
        end else begin
            wr.wr_data = s_data;
            strobe     = s_valid & s_ready;
        end
    end

    assign wr.wr_en = strobe & fifo_in_en;

    // radio cannot be stalled, so remember any sample lost to a full fifo
    always_ff @(posedge clk) begin
        if (!rstn) begin
            overflow <= 1'b0;
        end else if (radio_sel && radio_valid && fifo_in_en && wr.full) begin
            overflow <= 1'b1;
        end
    end

endmodule

// File: iq_sync_fifo.sv
// single clock fwft fifo

module iq_sync_fifo #(
    parameter int DEPTH = 2 ** (rx_iq_pkg::level_width - 1)
) (
    input  logic    clk,
    input  logic    rstn,
    iq_fifo_if.fifo q
);
    import rx_iq_pkg::*;

    // depth is a power of two so the pointers wrap on their own
    localparam int AW = $clog2(DEPTH);
    localparam int LW = AW + 1;

    iq_sample_t      mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [LW-1:0]   count;
    logic            do_wr;
    logic            do_rd;

    assign q.full    = (count == LW'(DEPTH));
    assign q.empty   = (count == '0);
    assign q.level   = count;
    assign q.rd_data = mem[rd_ptr];

    assign do_wr = q.wr_en & ~q.full;
    assign do_rd = q.rd_en & ~q.empty;

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= q.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rx_rate_ctrl.sv
// rx pacing control

module rx_rate_ctrl #(
    parameter int COUNT_TOP = rx_iq_pkg::count_top_default,
    parameter int LOW_MARK  = rx_iq_pkg::low_mark_default,
    parameter int HIGH_MARK = rx_iq_pkg::high_mark_default
) (
    input  logic    clk,
    input  logic    rstn,
    input  logic    free_run,
    input  logic    fifo_out_en,
    output logic    pace,
    output logic    trigger_out,
    iq_fifo_if.ctrl rd
);

    // must hold the stretched top of COUNT_TOP + 1
    localparam int CW = $clog2(COUNT_TOP + 2);

    logic [CW-1:0] counter;
    logic [CW-1:0] counter_top;
    logic [CW-1:0] next_top;
    logic          slot;

    assign slot = (counter == '0);

    // one tick per period, or every cycle in free run
    assign pace = slot | free_run;

    assign rd.rd_en = pace & ~rd.empty & fifo_out_en;

    // low fill reads slower, high fill reads faster
    always_comb begin
        if (rd.level < LOW_MARK) begin
            next_top = CW'(COUNT_TOP + 1);
        end else if (rd.level < HIGH_MARK) begin
            next_top = CW'(COUNT_TOP);
        end else begin
            next_top = CW'(COUNT_TOP - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            counter <= '0;
        end else if (counter == counter_top) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    // period is re-decided once per slot
    always_ff @(posedge clk) begin
        if (!rstn) begin
            counter_top <= CW'(COUNT_TOP);
        end else if (slot) begin
            counter_top <= next_top;
        end
    end

    // debug pulse when the period just moved
    always_ff @(posedge clk) begin
        if (!rstn) begin
            trigger_out <= 1'b0;
        end else begin
            trigger_out <= slot && (next_top != counter_top);
        end
    end

endmodule

// File: rx_iq_out_stage.sv
// rx iq output stage

module rx_iq_out_stage (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           valid_delay_sel,
    input  logic                           pop,
    input  rx_iq_pkg::iq_sample_t          head,
    output logic [rx_iq_pkg::iq_width-1:0] rf_i,
    output logic [rx_iq_pkg::iq_width-1:0] rf_q,
    output logic                           rf_valid,
    output rx_iq_pkg::iq_sample_t          rf_iq
);
    import rx_iq_pkg::*;

    iq_sample_t head_q;
    logic       pop_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pop_q <= 1'b0;
        end else begin
            pop_q <= pop;
        end
    end

    // hold the popped word for the delayed path
    always_ff @(posedge clk) begin
        if (pop) begin
            head_q <= head;
        end
    end

    assign rf_valid = valid_delay_sel ? pop_q : pop;
    assign rf_iq    = valid_delay_sel ? head_q : head;

    assign rf_i = rf_iq.i;
    assign rf_q = rf_iq.q;

endmodule

// File: rx_iq_intf.sv
// rx iq interface top

module rx_iq_intf #(
    parameter int DEPTH     = 2 ** (rx_iq_pkg::level_width - 1),
    parameter int COUNT_TOP = rx_iq_pkg::count_top_default,
    parameter int LOW_MARK  = rx_iq_pkg::low_mark_default,
    parameter int HIGH_MARK = rx_iq_pkg::high_mark_default
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [rx_iq_pkg::iq_width-1:0]   radio_i,
    input  logic [rx_iq_pkg::iq_width-1:0]   radio_q,
    input  logic                             radio_valid,
    input  logic [2*rx_iq_pkg::iq_width-1:0] s_data,
    input  logic                             s_valid,
    output logic                             s_ready,
    input  logic                             stream_en,
    input  logic                             fifo_in_en,
    input  logic                             fifo_out_en,
    input  logic                             free_run,
    input  logic [2:0]                       src_sel,
    input  logic                             valid_delay_sel,
    output logic [rx_iq_pkg::iq_width-1:0]   rf_i,
    output logic [rx_iq_pkg::iq_width-1:0]   rf_q,
    output logic                             rf_valid,
    output logic [2*rx_iq_pkg::iq_width-1:0] rf_iq,
    output logic                             fifo_emptyn,
    output logic                             overflow,
    output logic                             trigger_out
);
    import rx_iq_pkg::*;

    src_sel_e src_mode;
    logic     pace;

    assign src_mode = src_sel_e'(src_sel);

    iq_fifo_if #(.DEPTH(DEPTH)) fifo_bus ();

    iq_source_mux iq_source_mux_inst (
        .clk         (clk),
        .rstn        (rstn),
        .src_sel     (src_mode),
        .radio_i     (radio_i),
        .radio_q     (radio_q),
        .radio_valid (radio_valid),
        .s_data      (s_data),
        .s_valid     (s_valid),
        .stream_en   (stream_en),
        .fifo_in_en  (fifo_in_en),
        .pace        (pace),
        .s_ready     (s_ready),
        .overflow    (overflow),
        .wr          (fifo_bus.src)
    );

    iq_sync_fifo #(.DEPTH(DEPTH)) iq_sync_fifo_inst (
        .clk  (clk),
        .rstn (rstn),
        .q    (fifo_bus.fifo)
    );

    rx_rate_ctrl #(
        .COUNT_TOP (COUNT_TOP),
        .LOW_MARK  (LOW_MARK),
        .HIGH_MARK (HIGH_MARK)
    ) rx_rate_ctrl_inst (
        .clk         (clk),
        .rstn        (rstn),
        .free_run    (free_run),
        .fifo_out_en (fifo_out_en),
        .pace        (pace),
        .trigger_out (trigger_out),
        .rd          (fifo_bus.ctrl)
    );

    // pop strobe and head word taken straight off the fifo bus
    rx_iq_out_stage rx_iq_out_stage_inst (
        .clk             (clk),
        .rstn            (rstn),
        .valid_delay_sel (valid_delay_sel),
        .pop             (fifo_bus.rd_en),
        .head            (fifo_bus.rd_data),
        .rf_i            (rf_i),
        .rf_q            (rf_q),
        .rf_valid        (rf_valid),
        .rf_iq           (rf_iq)
    );

    assign fifo_emptyn = ~fifo_bus.empty;

endmodule

// File: tb_rx_iq_intf.sv
// rx iq interface testbench

module tb_rx_iq_intf;
    import rx_iq_pkg::*;

    localparam int depth        = 2 ** (level_width - 1);
    localparam int count_top    = count_top_default;
    localparam int low_mark     = low_mark_default;
    localparam int high_mark    = high_mark_default;
    localparam int per_max      = count_top + 2;
    localparam int rst_len      = 10;
    localparam int stream_words = 24;

    // rough length of each test in clocks
    localparam int t1_len = rst_len + 8 + 30;
    localparam int t2_len = 2 * rst_len + 4 * stream_words + 20 + depth + 16;
    localparam int t3_len = rst_len + 4 + 8 * per_max;
    localparam int t4_len = rst_len + (high_mark + 4) * (per_max + 1) + 4 * per_max;
    localparam int t5_len = 2 * (rst_len + 12 * (per_max + 1) + 4 * per_max);
    localparam int t6_len = rst_len + 2 * depth + 20;
    localparam int cycle_limit = 2 * (t1_len + t2_len + t3_len + t4_len + t5_len + t6_len);

    logic                  clk = 1'b0;
    logic                  rstn;
    logic [iq_width-1:0]   radio_i;
    logic [iq_width-1:0]   radio_q;
    logic                  radio_valid;
    logic [2*iq_width-1:0] s_data;
    logic                  s_valid;
    logic                  s_ready;
    logic                  stream_en;
    logic                  fifo_in_en;
    logic                  fifo_out_en;
    logic                  free_run;
    logic [2:0]            src_sel;
    logic                  valid_delay_sel;
    logic [iq_width-1:0]   rf_i;
    logic [iq_width-1:0]   rf_q;
    logic                  rf_valid;
    logic [2*iq_width-1:0] rf_iq;
    logic                  fifo_emptyn;
    logic                  overflow;
    logic                  trigger_out;

    // scoreboard and observed outputs
    iq_sample_t exp_q[$];
    iq_sample_t got_q[$];
    // rf_q and rf_i joined back into one sample
    iq_sample_t split_q[$];
    int         got_cyc[$];
    int         trig_q[$];
    iq_sample_t load_data [64];

    logic [31:0] lfsr;
    int          cycles = 0;
    int          base_cyc;
    int          sample_errs = 0;
    int          bit_errs = 0;
    int          count_errs = 0;

    rx_iq_intf rx_iq_intf_inst (
        .clk             (clk),
        .rstn            (rstn),
        .radio_i         (radio_i),
        .radio_q         (radio_q),
        .radio_valid     (radio_valid),
        .s_data          (s_data),
        .s_valid         (s_valid),
        .s_ready         (s_ready),
        .stream_en       (stream_en),
        .fifo_in_en      (fifo_in_en),
        .fifo_out_en     (fifo_out_en),
        .free_run        (free_run),
        .src_sel         (src_sel),
        .valid_delay_sel (valid_delay_sel),
        .rf_i            (rf_i),
        .rf_q            (rf_q),
        .rf_valid        (rf_valid),
        .rf_iq           (rf_iq),
        .fifo_emptyn     (fifo_emptyn),
        .overflow        (overflow),
        .trigger_out     (trigger_out)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d clocks, expected outputs never arrived", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_sample(input string name, input iq_sample_t actual,
                                input iq_sample_t expected);
        if (actual !== expected) begin
            $display("error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            sample_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("error at %0t: %s = %b, expected %b", $time, name, actual, expected);
            bit_errs++;
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
            count_errs++;
        end
    endtask

    // outputs are stable in the middle of the cycle
    always @(negedge clk) begin
        if (rstn && rf_valid) begin
            got_q.push_back(rf_iq);
            split_q.push_back({rf_q, rf_i});
            got_cyc.push_back(cycles);
        end
        if (rstn && trigger_out) begin
            trig_q.push_back(cycles);
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], rand_bit()};
        end
        return r;
    endfunction

    // pacing period for a given fill level before the pop
    function automatic int expected_gap(input int level);
        if (level < low_mark) begin
            return count_top + 2;
        end else if (level < high_mark) begin
            return count_top + 1;
        end
        return count_top;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic set_idle();
        radio_i         = '0;
        radio_q         = '0;
        radio_valid     = 1'b0;
        s_data          = '0;
        s_valid         = 1'b0;
        stream_en       = 1'b0;
        fifo_in_en      = 1'b0;
        fifo_out_en     = 1'b0;
        free_run        = 1'b0;
        src_sel         = src_radio;
        valid_delay_sel = 1'b0;
    endtask

    task automatic apply_reset();
        next_cycle();
        rstn = 1'b0;
        set_idle();
        repeat (8) next_cycle();
        rstn = 1'b1;
        base_cyc = cycles;
        exp_q.delete();
        got_q.delete();
        split_q.delete();
        got_cyc.delete();
        trig_q.delete();
    endtask

    task automatic fill_pattern();
        for (int k = 0; k < 64; k++) begin
            load_data[k] = rand_bits(32);
        end
    endtask

    // one radio sample per clock from the pattern
    task automatic load_radio(input int n);
        for (int k = 0; k < n; k++) begin
            radio_i     = load_data[k].i;
            radio_q     = load_data[k].q;
            radio_valid = 1'b1;
            exp_q.push_back(load_data[k]);
            next_cycle();
        end
        radio_valid = 1'b0;
    endtask

    task automatic wait_outputs(input int n);
        while (got_q.size() < n) begin
            next_cycle();
        end
    endtask

    task automatic compare_outputs();
        check_count("rf_valid pulses", got_q.size(), exp_q.size());
        for (int k = 0; k < got_q.size() && k < exp_q.size(); k++) begin
            check_sample("rf_iq", got_q[k], exp_q[k]);
            check_sample("rf_q:rf_i", split_q[k], exp_q[k]);
        end
    endtask

    // data held steady until taken
    task automatic stream_burst(input int cycles_max, input int words, input logic gaps,
                                output int accepted);
        logic xfer;
        xfer     = 1'b0;
        accepted = 0;
        s_valid  = 1'b0;
        for (int c = 0; c < cycles_max && accepted < words; c++) begin
            if (!s_valid || xfer) begin
                s_valid = gaps ? rand_bit() : 1'b1;
                s_data  = rand_bits(32);
            end
            @(negedge clk);
            xfer = s_valid && s_ready;
            if (xfer) begin
                accepted++;
                exp_q.push_back(s_data);
            end
            next_cycle();
        end
        s_valid = 1'b0;
    endtask

    task automatic load_and_drain(input int n, input logic delay);
        int want_trig[$];
        apply_reset();
        src_sel         = src_radio;
        fifo_in_en      = 1'b1;
        valid_delay_sel = delay;
        load_radio(n);
        // let the period settle on the loaded level
        repeat (3 * per_max) next_cycle();
        trig_q.delete();
        fifo_out_en = 1'b1;
        wait_outputs(n);
        repeat (per_max) next_cycle();
        compare_outputs();
        for (int i = 1; i < n && i < got_cyc.size(); i++) begin
            check_count("rf_valid spacing", got_cyc[i] - got_cyc[i-1], expected_gap(n - i + 1));
            if (expected_gap(n - i) != expected_gap(n - i + 1)) begin
                want_trig.push_back(got_cyc[i] + 1 - int'(delay));
            end
        end
        check_count("trigger_out pulses", trig_q.size(), want_trig.size());
        for (int k = 0; k < trig_q.size() && k < want_trig.size(); k++) begin
            check_count("trigger_out cycle", trig_q[k], want_trig[k]);
        end
    endtask

    task automatic test_reset_and_radio();
        apply_reset();
        @(negedge clk);
        check_bit("rf_valid", rf_valid, 1'b0);
        check_bit("s_ready", s_ready, 1'b0);
        check_bit("trigger_out", trigger_out, 1'b0);
        check_bit("fifo_emptyn", fifo_emptyn, 1'b0);
        next_cycle();
        src_sel     = src_radio;
        fifo_in_en  = 1'b1;
        fifo_out_en = 1'b1;
        free_run    = 1'b1;
        fill_pattern();
        load_radio(8);
        wait_outputs(8);
        repeat (4) next_cycle();
        compare_outputs();
    endtask

    task automatic test_stream();
        int acc;
        apply_reset();
        src_sel     = src_stream;
        stream_en   = 1'b1;
        fifo_in_en  = 1'b1;
        fifo_out_en = 1'b1;
        free_run    = 1'b1;
        stream_burst(4 * stream_words + 20, stream_words, 1'b1, acc);
        check_count("accepted words", acc, stream_words);
        wait_outputs(acc);
        repeat (4) next_cycle();
        compare_outputs();
        // reader held off until the fifo fills
        apply_reset();
        src_sel    = src_stream;
        stream_en  = 1'b1;
        fifo_in_en = 1'b1;
        free_run   = 1'b1;
        stream_burst(depth + 8, depth + 8, 1'b0, acc);
        check_count("accepted words at full", acc, depth);
        @(negedge clk);
        check_bit("s_ready", s_ready, 1'b0);
        check_bit("fifo_emptyn", fifo_emptyn, 1'b1);
    endtask

    task automatic test_delay_select();
        iq_sample_t ref_q[$];
        int         ref_cyc[$];
        fill_pattern();
        load_and_drain(12, 1'b0);
        ref_q = got_q;
        foreach (got_cyc[k]) begin
            ref_cyc.push_back(got_cyc[k] - base_cyc);
        end
        load_and_drain(12, 1'b1);
        check_count("delayed pulses", got_q.size(), ref_q.size());
        for (int k = 0; k < got_q.size() && k < ref_q.size(); k++) begin
            check_sample("rf_iq delayed", got_q[k], ref_q[k]);
            check_count("rf_valid delayed cycle", got_cyc[k] - base_cyc, ref_cyc[k] + 1);
        end
    endtask

    task automatic test_overflow();
        apply_reset();
        src_sel    = src_radio;
        fifo_in_en = 1'b1;
        fill_pattern();
        @(negedge clk);
        check_bit("overflow", overflow, 1'b0);
        next_cycle();
        load_radio(depth + 4);
        // the last four never fit
        repeat (4) void'(exp_q.pop_back());
        @(negedge clk);
        check_bit("overflow", overflow, 1'b1);
        next_cycle();
        free_run    = 1'b1;
        fifo_out_en = 1'b1;
        wait_outputs(depth);
        repeat (4) next_cycle();
        compare_outputs();
    endtask

    initial begin
        rstn = 1'b0;
        set_idle();
        lfsr = 32'he36ceb09;
        test_reset_and_radio();
        test_stream();
        fill_pattern();
        load_and_drain(4, 1'b0);
        fill_pattern();
        load_and_drain(high_mark + 4, 1'b0);
        test_delay_select();
        test_overflow();
        $display("errors: samples %0d, bits %0d, counts %0d",
                 sample_errs, bit_errs, count_errs);
        if (sample_errs + bit_errs + count_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sim.f
rx_iq_pkg.sv
iq_fifo_if.sv
iq_source_mux.sv
iq_sync_fifo.sv
rx_rate_ctrl.sv
rx_iq_out_stage.sv
rx_iq_intf.sv
tb_rx_iq_intf.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rx iq testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_rx_iq_intf -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
else
    exit 1
fi
